//--- rtl/RvPkg.sv
package RvPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;

	typedef enum logic [3:0] {
		AluAdd,
		AluSub,
		AluSll,
		AluSlt,
		AluSltu,
		AluXor,
		AluSrl,
		AluSra,
		AluOr,
		AluAnd,
		AluPassB
	} aluOp_t;

	typedef enum logic [2:0] {
		BrNone,
		BrEq,
		BrNe,
		BrLt,
		BrGe,
		BrLtu,
		BrGeu,
		BrJump
	} brCond_t;

	typedef enum logic {
		FwdReg,
		FwdEx
	} fwdSel_t;

	localparam opcode_t OpLui = 7'b0110111;
	localparam opcode_t OpAuipc = 7'b0010111;
	localparam opcode_t OpJal = 7'b1101111;
	localparam opcode_t OpBranch = 7'b1100011;
	localparam opcode_t OpImm = 7'b0010011;
	localparam opcode_t OpReg = 7'b0110011;
	localparam opcode_t OpSystem = 7'b1110011;

	// Only system instruction that is decoded
	localparam word_t InstrEbreak = 32'h00100073;

endpackage

//--- rtl/InstrDecoder.sv
`timescale 1ns/1ps

module InstrDecoder import RvPkg::*; (
	input word_t instr,
	output regAddr_t rs1,
	output regAddr_t rs2,
	output regAddr_t rd,
	output word_t imm,
	output aluOp_t aluOp,
	output brCond_t brCond,
	output logic srcAPc,
	output logic srcBImm,
	output logic regWe,
	output logic useRs1,
	output logic useRs2,
	output logic isHalt
);

	opcode_t opcode;
	funct3_t funct3;
	word_t immI;
	word_t immU;
	word_t immB;
	word_t immJ;

	// funct3 to ALU op; alt picks SUB or SRA
	function automatic aluOp_t aluFromFunct(input funct3_t f3, input logic alt);
		case (f3)
			3'b000: return alt ? AluSub : AluAdd;
			3'b001: return AluSll;
			3'b010: return AluSlt;
			3'b011: return AluSltu;
			3'b100: return AluXor;
			3'b101: return alt ? AluSra : AluSrl;
			3'b110: return AluOr;
			default: return AluAnd;
		endcase
	endfunction

	function automatic brCond_t brFromFunct(input funct3_t f3);
		case (f3)
			3'b000: return BrEq;
			3'b001: return BrNe;
			3'b100: return BrLt;
			3'b101: return BrGe;
			3'b110: return BrLtu;
			3'b111: return BrGeu;
			default: return BrNone;
		endcase
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immU = {instr[31:12], 12'b0};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		// Anything not listed below is a NOP
		imm = '0;
		aluOp = AluAdd;
		brCond = BrNone;
		srcAPc = 1'b0;
		srcBImm = 1'b0;
		regWe = 1'b0;
		useRs1 = 1'b0;
		useRs2 = 1'b0;
		isHalt = 1'b0;
		case (opcode)
			OpLui: begin
				imm = immU;
				aluOp = AluPassB;
				srcBImm = 1'b1;
				regWe = 1'b1;
			end
			OpAuipc: begin
				imm = immU;
				srcAPc = 1'b1;
				srcBImm = 1'b1;
				regWe = 1'b1;
			end
			OpJal: begin
				imm = immJ;
				brCond = BrJump;
				regWe = 1'b1;
			end
			OpBranch: begin
				imm = immB;
				brCond = brFromFunct(funct3);
				useRs1 = 1'b1;
				useRs2 = 1'b1;
			end
			OpImm: begin
				imm = immI;
				// Only shifts carry a funct7 bit here
				aluOp = aluFromFunct(funct3, funct3 == 3'b101 && instr[30]);
				srcBImm = 1'b1;
				regWe = 1'b1;
				useRs1 = 1'b1;
			end
			OpReg: begin
				aluOp = aluFromFunct(funct3, instr[30]);
				regWe = 1'b1;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
			end
			OpSystem: begin
				isHalt = (instr == InstrEbreak);
			end
			default: ;
		endcase
	end

endmodule

//--- rtl/RegFile.sv
`timescale 1ns/1ps

module RegFile import RvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input regAddr_t ra1,
	input regAddr_t ra2,
	input regAddr_t wa,
	input logic we,
	input word_t wd,
	output word_t rd1,
	output word_t rd2
);

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

	// Execute stage must never retire a write to x0
	assert property (@(posedge CLK) disable iff (RSTn) we |-> wa != '0)
		else $error("write to x0 requested");

endmodule

//--- rtl/HazardUnit.sv
`timescale 1ns/1ps

module HazardUnit import RvPkg::*; (
	input regAddr_t rs1,
	input regAddr_t rs2,
	input logic useRs1,
	input logic useRs2,
	input regAddr_t exRd,
	input logic exWe,
	input logic exValid,
	input logic redirectValid,
	input logic instrValid,
	input logic halted,
	input logic exHalt,
	output fwdSel_t fwdA,
	output fwdSel_t fwdB,
	output logic flushIdEx
);

	logic exWrites;

	// Execute stage result is live this cycle
	assign exWrites = exValid && exWe && exRd != '0;

	assign fwdA = (useRs1 && exWrites && rs1 == exRd) ? FwdEx : FwdReg;
	assign fwdB = (useRs2 && exWrites && rs2 == exRd) ? FwdEx : FwdReg;

	// Bubble on empty fetch, wrong path, or halt
	assign flushIdEx = !instrValid || redirectValid || halted || exHalt;

endmodule

//--- rtl/IdExReg.sv
`timescale 1ns/1ps

module IdExReg import RvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic flush,
	input word_t pcIn,
	input word_t immIn,
	input word_t rs1DataIn,
	input word_t rs2DataIn,
	input regAddr_t rdIn,
	input aluOp_t aluOpIn,
	input brCond_t brCondIn,
	input logic srcAPcIn,
	input logic srcBImmIn,
	input logic regWeIn,
	input logic haltIn,
	output logic valid,
	output word_t pc,
	output word_t imm,
	output word_t rs1Data,
	output word_t rs2Data,
	output regAddr_t rd,
	output aluOp_t aluOp,
	output brCond_t brCond,
	output logic srcAPc,
	output logic srcBImm,
	output logic regWe,
	output logic halt
);

	always_ff @(posedge CLK) begin
		if (RSTn || flush) begin
			// Bubble with every field back to zero
			valid <= 1'b0;
			pc <= '0;
			imm <= '0;
			rs1Data <= '0;
			rs2Data <= '0;
			rd <= '0;
			aluOp <= AluAdd;
			brCond <= BrNone;
			srcAPc <= 1'b0;
			srcBImm <= 1'b0;
			regWe <= 1'b0;
			halt <= 1'b0;
		end else begin
			valid <= 1'b1;
			pc <= pcIn;
			imm <= immIn;
			rs1Data <= rs1DataIn;
			rs2Data <= rs2DataIn;
			rd <= rdIn;
			aluOp <= aluOpIn;
			brCond <= brCondIn;
			srcAPc <= srcAPcIn;
			srcBImm <= srcBImmIn;
			regWe <= regWeIn;
			halt <= haltIn;
		end
	end

endmodule

//--- rtl/ExecuteUnit.sv
`timescale 1ns/1ps

module ExecuteUnit import RvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic valid,
	input word_t pc,
	input word_t imm,
	input word_t rs1Data,
	input word_t rs2Data,
	input regAddr_t rd,
	input aluOp_t aluOp,
	input brCond_t brCond,
	input logic srcAPc,
	input logic srcBImm,
	input logic regWe,
	input logic halt,
	output logic redirectValid,
	output word_t redirectPc,
	output logic retValid,
	output logic retWe,
	output regAddr_t retRd,
	output word_t retPc,
	output word_t retData,
	output logic exHalt,
	output logic halted
);

	word_t opA;
	word_t opB;
	word_t aluResult;
	logic taken;

	assign opA = srcAPc ? pc : rs1Data;
	assign opB = srcBImm ? imm : rs2Data;

	always_comb begin
		case (aluOp)
			AluAdd: aluResult = opA + opB;
			AluSub: aluResult = opA - opB;
			AluSll: aluResult = opA << opB[4:0];
			AluSlt: aluResult = word_t'($signed(opA) < $signed(opB));
			AluSltu: aluResult = word_t'(opA < opB);
			AluXor: aluResult = opA ^ opB;
			AluSrl: aluResult = opA >> opB[4:0];
			AluSra: aluResult = word_t'($signed(opA) >>> opB[4:0]);
			AluOr: aluResult = opA | opB;
			AluAnd: aluResult = opA & opB;
			default: aluResult = opB;
		endcase
	end

	// Compare on register operands, never on the immediate
	always_comb begin
		case (brCond)
			BrEq: taken = rs1Data == rs2Data;
			BrNe: taken = rs1Data != rs2Data;
			BrLt: taken = $signed(rs1Data) < $signed(rs2Data);
			BrGe: taken = $signed(rs1Data) >= $signed(rs2Data);
			BrLtu: taken = rs1Data < rs2Data;
			BrGeu: taken = rs1Data >= rs2Data;
			BrJump: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign redirectValid = valid && taken;
	assign redirectPc = pc + imm;

	assign retValid = valid;
	assign retWe = valid && regWe && rd != '0;
	assign retRd = rd;
	assign retPc = pc;
	// Link address for JAL
	assign retData = (brCond == BrJump) ? pc + 32'd4 : aluResult;

	assign exHalt = valid && halt;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			halted <= 1'b0;
		end else if (exHalt) begin
			halted <= 1'b1;
		end
	end

	// Nothing reaches execute once halted
	assert property (@(posedge CLK) disable iff (RSTn) halted |-> !retValid)
		else $error("retire after halt");

endmodule

//--- rtl/DecodeExecute.sv
`timescale 1ns/1ps

module DecodeExecute import RvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic instrValid,
	input word_t instr,
	input word_t pc,
	output logic redirectValid,
	output word_t redirectPc,
	output logic retValid,
	output logic retWe,
	output regAddr_t retRd,
	output word_t retPc,
	output word_t retData,
	output logic halted
);

	regAddr_t rs1, rs2, rd;
	word_t imm;
	aluOp_t aluOp;
	brCond_t brCond;
	logic srcAPc, srcBImm, regWe, useRs1, useRs2, isHalt;

	word_t rd1, rd2;
	word_t opA, opB;
	fwdSel_t fwdA, fwdB;
	logic flushIdEx;
	logic exHalt;

	logic exValid;
	word_t exPc, exImm, exRs1Data, exRs2Data;
	regAddr_t exRd;
	aluOp_t exAluOp;
	brCond_t exBrCond;
	logic exSrcAPc, exSrcBImm, exRegWe, exHaltFlag;

	InstrDecoder i_decoder (
		.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.aluOp(aluOp), .brCond(brCond), .srcAPc(srcAPc), .srcBImm(srcBImm),
		.regWe(regWe), .useRs1(useRs1), .useRs2(useRs2), .isHalt(isHalt)
	);

	RegFile i_regFile (
		.CLK(CLK), .RSTn(RSTn), .ra1(rs1), .ra2(rs2), .wa(retRd),
		.we(retValid && retWe), .wd(retData), .rd1(rd1), .rd2(rd2)
	);

	HazardUnit i_hazard (
		.rs1(rs1), .rs2(rs2), .useRs1(useRs1), .useRs2(useRs2),
		.exRd(retRd), .exWe(retWe), .exValid(retValid),
		.redirectValid(redirectValid), .instrValid(instrValid),
		.halted(halted), .exHalt(exHalt),
		.fwdA(fwdA), .fwdB(fwdB), .flushIdEx(flushIdEx)
	);

	// Execute result bypasses the register file write
	assign opA = (fwdA == FwdEx) ? retData : rd1;
	assign opB = (fwdB == FwdEx) ? retData : rd2;

	IdExReg i_idEx (
		.CLK(CLK), .RSTn(RSTn), .flush(flushIdEx),
		.pcIn(pc), .immIn(imm), .rs1DataIn(opA), .rs2DataIn(opB), .rdIn(rd),
		.aluOpIn(aluOp), .brCondIn(brCond), .srcAPcIn(srcAPc),
		.srcBImmIn(srcBImm), .regWeIn(regWe), .haltIn(isHalt),
		.valid(exValid), .pc(exPc), .imm(exImm), .rs1Data(exRs1Data),
		.rs2Data(exRs2Data), .rd(exRd), .aluOp(exAluOp), .brCond(exBrCond),
		.srcAPc(exSrcAPc), .srcBImm(exSrcBImm), .regWe(exRegWe), .halt(exHaltFlag)
	);

	ExecuteUnit i_execute (
		.CLK(CLK), .RSTn(RSTn), .valid(exValid), .pc(exPc), .imm(exImm),
		.rs1Data(exRs1Data), .rs2Data(exRs2Data), .rd(exRd), .aluOp(exAluOp),
		.brCond(exBrCond), .srcAPc(exSrcAPc), .srcBImm(exSrcBImm),
		.regWe(exRegWe), .halt(exHaltFlag),
		.redirectValid(redirectValid), .redirectPc(redirectPc),
		.retValid(retValid), .retWe(retWe), .retRd(retRd), .retPc(retPc),
		.retData(retData), .exHalt(exHalt), .halted(halted)
	);

endmodule

//--- tb/RefModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

localparam int ModeAlu = 0;
localparam int ModeFwd = 1;
localparam int ModeFwdX0 = 2;
localparam int ModeBranch = 3;

word_t prog [0:255];
word_t modelRegs [0:31];
word_t modelPc;
logic modelHalted;

// RV32I integer op, alt is instruction bit 30
function automatic word_t aluModel(input logic [2:0] f3, input logic alt, input word_t a,
		input word_t b);
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'd3: return (a < b) ? 32'd1 : 32'd0;
		3'd4: return a ^ b;
		3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic branchTaken(input logic [2:0] f3, input word_t a, input word_t b);
	case (f3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return $signed(a) < $signed(b);
		3'd5: return $signed(a) >= $signed(b);
		3'd6: return a < b;
		3'd7: return a >= b;
		default: return 1'b0;
	endcase
endfunction

// Executes the instruction at modelPc and returns what it retires
function automatic void modelStep(output logic we, output regAddr_t rdOut,
		output word_t data, output logic taken, output word_t target);
	word_t ins;
	word_t a;
	word_t b;
	ins = prog[modelPc[9:2]];
	a = modelRegs[ins[19:15]];
	b = modelRegs[ins[24:20]];
	rdOut = ins[11:7];
	we = 1'b0;
	data = '0;
	taken = 1'b0;
	target = modelPc + 32'd4;
	case (ins[6:0])
		OpLui: begin
			we = 1'b1;
			data = {ins[31:12], 12'b0};
		end
		OpAuipc: begin
			we = 1'b1;
			data = modelPc + {ins[31:12], 12'b0};
		end
		OpJal: begin
			we = 1'b1;
			data = modelPc + 32'd4;
			taken = 1'b1;
			target = modelPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		end
		OpBranch: begin
			taken = branchTaken(ins[14:12], a, b);
			if (taken)
				target = modelPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		end
		OpImm: begin
			we = 1'b1;
			data = aluModel(ins[14:12], ins[14:12] == 3'd5 && ins[30], a,
				{{20{ins[31]}}, ins[31:20]});
		end
		OpReg: begin
			we = 1'b1;
			data = aluModel(ins[14:12], ins[30], a, b);
		end
		OpSystem: begin
			if (ins == InstrEbreak)
				modelHalted = 1'b1;
		end
		default: ;
	endcase
	if (rdOut == '0)
		we = 1'b0;
	if (we)
		modelRegs[rdOut] = data;
	modelPc = target;
endfunction

// Small register sets make back-to-back dependencies likely
function automatic regAddr_t pickReg(input int mode);
	case (mode)
		ModeAlu: return regAddr_t'($random(seed));
		ModeFwdX0: return regAddr_t'($unsigned($random(seed)) % 3);
		default: return regAddr_t'(1 + $unsigned($random(seed)) % 3);
	endcase
endfunction

function automatic word_t randomInstr(input int mode, input int idx, input int len);
	int kind;
	int slots;
	int k;
	word_t r;
	word_t off;
	regAddr_t rd;
	regAddr_t rs1;
	regAddr_t rs2;
	logic [2:0] f3;
	logic alt;
	kind = $unsigned($random(seed)) % ((mode == ModeBranch) ? 6 : 4);
	rd = pickReg(mode);
	rs1 = pickReg(mode);
	rs2 = pickReg(mode);
	r = $random(seed);
	f3 = r[14:12];
	alt = r[30];
	slots = len - 1 - idx;
	// Forward only, never past the closing EBREAK
	off = 4 * (1 + $unsigned($random(seed)) % ((slots < 6) ? slots : 6));
	case (kind)
		0: begin
			if (f3 == 3'd1 || f3 == 3'd5)
				r[31:25] = {1'b0, alt && f3 == 3'd5, 5'b0};
			return {r[31:20], rs1, f3, rd, OpImm};
		end
		1: return {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, OpReg};
		2: return {r[31:12], rd, OpLui};
		3: return {r[31:12], rd, OpAuipc};
		4: begin
			k = $unsigned($random(seed)) % 6;
			f3 = 3'((k < 2) ? k : k + 2);
			return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OpBranch};
		end
		default: return {off[20], off[10:1], off[11], off[19:12], rd, OpJal};
	endcase
endfunction

function automatic void loadProgram(input int mode, input int len);
	for (int i = 0; i < 256; i++) begin
		prog[i] = (i < len - 1) ? randomInstr(mode, i, len) : InstrEbreak;
	end
	for (int i = 0; i < 32; i++) begin
		modelRegs[i] = '0;
	end
	modelPc = '0;
	modelHalted = 1'b0;
endfunction

`endif

//--- tb/tbDecodeExecute.sv
`timescale 1ns/1ps

module tbDecodeExecute import RvPkg::*; ();

	localparam int TotalLength = 48 + 48 + 48 + 64 + 16;
	localparam int TimeoutCycles = 2 * TotalLength + 100;

	logic CLK;
	logic RSTn;
	logic instrValid;
	word_t instr;
	word_t pc;
	logic redirectValid;
	word_t redirectPc;
	logic retValid;
	logic retWe;
	regAddr_t retRd;
	word_t retPc;
	word_t retData;
	logic halted;

	integer seed = 32'hc81e94a5;
	int errorCount = 0;
	int retireCount = 0;
	int testCount = 0;
	int cycleCount = 0;
	word_t fetchPc;

	`include "RefModel.svh"

	DecodeExecute i_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount > TimeoutCycles) begin
			$display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic mismatch(input string name, input word_t expected, input word_t actual);
		errorCount++;
		$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	task automatic failure(input string what);
		errorCount++;
		$display("At %0t: %s", $time, what);
	endtask

	task automatic present(input word_t addr);
		fetchPc = addr;
		pc = addr;
		instr = prog[addr[9:2]];
		instrValid = 1'b1;
	endtask

	task automatic applyReset();
		RSTn = 1'b1;
		instrValid = 1'b0;
		repeat (3) @(posedge CLK);
		#1;
		RSTn = 1'b0;
	endtask

	// Sampled mid-cycle while the retire outputs are settled
	task automatic checkRetire();
		logic eWe;
		regAddr_t eRd;
		word_t eData;
		logic eTaken;
		word_t eTarget;
		word_t ePc;
		if (!retValid) begin
			if (redirectValid)
				failure("redirect raised with no instruction retiring");
			return;
		end
		ePc = modelPc;
		modelStep(eWe, eRd, eData, eTaken, eTarget);
		retireCount++;
		if (retPc !== ePc) mismatch("retPc", ePc, retPc);
		if (retWe !== eWe) mismatch("retWe", 32'(eWe), 32'(retWe));
		if (eWe && retRd !== eRd) mismatch("retRd", 32'(eRd), 32'(retRd));
		if (eWe && retData !== eData) mismatch("retData", eData, retData);
		if (redirectValid !== eTaken) mismatch("redirectValid", 32'(eTaken), 32'(redirectValid));
		if (eTaken && redirectPc !== eTarget) mismatch("redirectPc", eTarget, redirectPc);
	endtask

	task automatic runProgram(input string name, input int mode, input int len, input int hold);
		int errorsBefore;
		int retiresBefore;
		logic redir;
		word_t redirTarget;
		errorsBefore = errorCount;
		retiresBefore = retireCount;
		loadProgram(mode, len);
		applyReset();
		present(32'h0);
		while (!halted) begin
			@(negedge CLK);
			checkRetire();
			redir = redirectValid;
			redirTarget = redirectPc;
			@(posedge CLK);
			#1;
			present(redir ? redirTarget : fetchPc + 32'd4);
		end
		if (!modelHalted)
			failure("halted went high before EBREAK retired");
		// Fetch keeps offering words, none may retire
		repeat (hold) begin
			@(negedge CLK);
			if (retValid) failure("instruction retired after halt");
			if (!halted) failure("halted dropped before reset");
			@(posedge CLK);
			#1;
			present(fetchPc + 32'd4);
		end
		testCount++;
		$display("Test %s: %0d retired, %0d errors", name, retireCount - retiresBefore,
			errorCount - errorsBefore);
	endtask

	initial begin
		RSTn = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		fetchPc = '0;
		applyReset();
		// Empty fetch slots carry junk words
		repeat (8) begin
			@(negedge CLK);
			if (retValid) failure("retire with no valid instruction fetched");
			if (redirectValid) failure("redirect high out of reset");
			if (halted) failure("halted high out of reset");
			@(posedge CLK);
			#1;
			instr = $random(seed);
		end
		testCount++;
		$display("Test resetState: %0d errors", errorCount);
		runProgram("aluOps", ModeAlu, 48, 4);
		runProgram("forwarding", ModeFwd, 48, 4);
		runProgram("forwardingX0", ModeFwdX0, 48, 4);
		runProgram("branches", ModeBranch, 64, 4);
		runProgram("halt", ModeBranch, 16, 20);
		$display("Tests: %0d, retired: %0d, errors: %0d", testCount, retireCount, errorCount);
		if (errorCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tb.f
+incdir+tb
rtl/RvPkg.sv
rtl/InstrDecoder.sv
rtl/RegFile.sv
rtl/HazardUnit.sv
rtl/IdExReg.sv
rtl/ExecuteUnit.sv
rtl/DecodeExecute.sv
tb/tbDecodeExecute.sv

//--- Bender.yml
package:
  name: decode_execute

sources:
  - files:
      - rtl/RvPkg.sv
      - rtl/InstrDecoder.sv
      - rtl/RegFile.sv
      - rtl/HazardUnit.sv
      - rtl/IdExReg.sv
      - rtl/ExecuteUnit.sv
      - rtl/DecodeExecute.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tbDecodeExecute.sv
